//--- div_unit.f
hdl/div_cfg_pkg.sv
hdl/div_msg_pkg.sv
hdl/div_req_stage.sv
hdl/div_iter_core.sv
hdl/div_resp_stage.sv
hdl/div_unit.sv
dv/div_clk_gen.sv
dv/div_unit_props.sv
dv/div_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds the divide unit testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f div_unit.f --top-module div_unit_tb -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

# assertion errors are reported but do not stop the run
out=$(./obj_dir/Vdiv_unit_tb +verilator+error+limit+1000 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "Simulation completed successfully"; then
  exit 0
else
  exit 1
fi

//--- dv/div_unit_tb.sv
// ----------------------------------------------------------
// divide unit testbench with stimulus, reference model and monitor
// compare tasks, per-test report and closing summary
// ----------------------------------------------------------

`timescale 1ns/1ps

module div_unit_tb
  import div_msg_pkg::*;
();

  localparam int resp_latency = 34;
  localparam int wait_limit   = 200;

  logic      clk;
  logic      reset;
  div_req_t  req;
  logic      req_val;
  logic      req_rdy;
  div_resp_t resp;
  logic      resp_val;
  logic      resp_rdy;

  // bookkeeping shared by driver and monitor
  int        err_cnt      = 0;
  int        check_cnt    = 0;
  int        tests_failed = 0;
  int        edge_cnt     = 0;
  int        err_at_start = 0;
  bit        timed_out    = 1'b0;
  bit        in_flight    = 1'b0;
  bit        resp_val_q   = 1'b0;
  bit        stall_q      = 1'b0;
  div_resp_t held_resp;
  div_resp_t exp_q[$];
  int        acc_q[$];

  div_clk_gen clk_gen (.clk(clk));

  div_unit uut (
    .clk      (clk),
    .reset    (reset),
    .req      (req),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp     (resp),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy)
  );

  // ----------------------------------------------------------
  // reference model and compare tasks
  // ----------------------------------------------------------

  function automatic div_resp_t ref_div(input div_req_t r);
    div_resp_t res;
    int        sa;
    int        sb;
    sa = r.a;
    sb = r.b;
    if (r.b == '0) begin
      // all ones magnitude negated for a negative signed dividend
      res.quot = (r.fn == DIV_FN_SIGNED && sa < 0) ? 32'd1 : 32'hffff_ffff;
      res.rem  = r.a;
    end else if (r.fn == DIV_FN_UNSIGNED) begin
      res.quot = r.a / r.b;
      res.rem  = r.a % r.b;
    end else if (r.a == 32'h8000_0000 && r.b == 32'hffff_ffff) begin
      // overflow wraps to the most negative value
      res.quot = 32'h8000_0000;
      res.rem  = '0;
    end else begin
      // truncates toward zero and the remainder keeps the dividend sign
      res.quot = sa / sb;
      res.rem  = sa % sb;
    end
    return res;
  endfunction

  function automatic div_req_t make_req(input div_fn_e fn, input logic [31:0] a,
                                        input logic [31:0] b);
    div_req_t r;
    r.fn = fn;
    r.a  = a;
    r.b  = b;
    return r;
  endfunction

  // checker errors plus failed bound assertions
  function automatic int total_errors();
    return err_cnt + uut.props.fail_cnt;
  endfunction

  task automatic check_resp(input string name, input div_resp_t got, input div_resp_t exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("[ERROR] %0t %s: got rem %h quot %h, expected rem %h quot %h",
               $time, name, got.rem, got.quot, exp.rem, exp.quot);
    end
  endtask

  task automatic check_latency(input int got, input int exp);
    check_cnt++;
    if (got != exp) begin
      err_cnt++;
      $display("[ERROR] %0t resp_val latency: got %0d edges, expected %0d", $time, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("[ERROR] %0t %s: got %b, expected %b", $time, name, got, exp);
    end
  endtask

  // ----------------------------------------------------------
  // monitor sampling pre-edge values at each rising edge
  // ----------------------------------------------------------

  always @(posedge clk) begin
    if (reset) begin
      in_flight  = 1'b0;
      resp_val_q = 1'b0;
      stall_q    = 1'b0;
    end else begin
      if (in_flight) begin
        check_flag("req_rdy", req_rdy, 1'b0);
      end
      // a high resp_val seen here was set by the previous edge
      if (resp_val && !resp_val_q && acc_q.size() > 0) begin
        check_latency(edge_cnt - 1 - acc_q[0], resp_latency);
      end
      if (resp_val && stall_q) begin
        check_resp("resp held", resp, held_resp);
      end
      if (resp_val && resp_rdy) begin
        if (exp_q.size() == 0) begin
          err_cnt++;
          $display("response transferred at %0t with no request outstanding", $time);
        end else begin
          check_resp("resp", resp, exp_q.pop_front());
          void'(acc_q.pop_front());
        end
        in_flight = 1'b0;
      end
      if (req_val && req_rdy) begin
        exp_q.push_back(ref_div(req));
        acc_q.push_back(edge_cnt);
        in_flight = 1'b1;
      end
      stall_q    = resp_val && !resp_rdy;
      held_resp  = resp;
      resp_val_q = resp_val;
    end
    edge_cnt++;
  end

  // ----------------------------------------------------------
  // driver tasks entered and left on a falling edge
  // ----------------------------------------------------------

  task automatic report_timeout(input string what);
    $display("timeout: %s did not happen within %0d cycles, at %0t", what, wait_limit, $time);
    timed_out = 1'b1;
  endtask

  task automatic wait_accept();
    int n;
    n = 0;
    while (!timed_out && !req_rdy && n < wait_limit) begin
      @(negedge clk);
      n++;
    end
    if (!req_rdy) begin
      report_timeout("request acceptance");
    end else begin
      // the rising edge in between takes the request
      @(negedge clk);
      req_val = 1'b0;
    end
  endtask

  task automatic send_req(input div_req_t r);
    req     = r;
    req_val = 1'b1;
    wait_accept();
  endtask

  task automatic wait_resp_val(output int edges);
    edges = 0;
    while (!timed_out && !resp_val && edges < wait_limit) begin
      @(negedge clk);
      edges++;
    end
    if (!resp_val) begin
      report_timeout("resp_val");
    end
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while (!timed_out && (exp_q.size() != 0 || resp_val || !req_rdy) && n < wait_limit) begin
      @(negedge clk);
      n++;
    end
    if (exp_q.size() != 0 || resp_val || !req_rdy) begin
      report_timeout("return to idle");
    end
  endtask

  // ----------------------------------------------------------
  // tests
  // ----------------------------------------------------------

  task automatic test_reset_back_to_back();
    div_req_t r;
    check_flag("req_rdy", req_rdy, 1'b1);
    check_flag("resp_val", resp_val, 1'b0);
    for (int i = 0; i < 8; i++) begin
      r.fn = ($urandom & 1) != 0 ? DIV_FN_SIGNED : DIV_FN_UNSIGNED;
      r.a  = $urandom;
      r.b  = $urandom >> ($urandom % 32);
      send_req(r);
    end
  endtask

  task automatic test_unsigned();
    logic [31:0] b;
    for (int i = 0; i < 16; i++) begin
      b = $urandom >> ($urandom % 32);
      send_req(make_req(DIV_FN_UNSIGNED, $urandom, (b == '0) ? 32'd7 : b));
    end
  endtask

  task automatic test_signed();
    logic [31:0] a;
    logic [31:0] b;
    int          k;
    for (int i = 0; i < 12; i++) begin
      // bit 1 negates the dividend and bit 0 the divisor
      k = i % 4;
      a = $urandom & 32'h7fff_ffff;
      b = ($urandom >> ($urandom % 31)) & 32'h7fff_ffff;
      b = (b == '0) ? 32'd5 : b;
      a = k[1] ? -a : a;
      b = k[0] ? -b : b;
      send_req(make_req(DIV_FN_SIGNED, a, b));
    end
  endtask

  task automatic test_zero_overflow();
    send_req(make_req(DIV_FN_UNSIGNED, $urandom, 32'd0));
    send_req(make_req(DIV_FN_UNSIGNED, 32'd0, 32'd0));
    send_req(make_req(DIV_FN_SIGNED, 32'd1234, 32'd0));
    send_req(make_req(DIV_FN_SIGNED, 32'hffff_fb2e, 32'd0));
    send_req(make_req(DIV_FN_SIGNED, 32'h8000_0000, 32'hffff_ffff));
    send_req(make_req(DIV_FN_SIGNED, 32'h8000_0000, 32'd1));
  endtask

  task automatic test_latency();
    int edges;
    send_req(make_req(DIV_FN_SIGNED, $urandom, $urandom | 32'd1));
    check_flag("req_rdy", req_rdy, 1'b0);
    // counts the rising edges after the acceptance edge
    wait_resp_val(edges);
    if (!timed_out) begin
      check_latency(edges, resp_latency);
    end
  endtask

  task automatic test_back_pressure();
    div_resp_t held;
    int        edges;
    int        hold;
    resp_rdy = 1'b0;
    send_req(make_req(DIV_FN_SIGNED, $urandom, $urandom | 32'd1));
    wait_resp_val(edges);
    held = resp;
    hold = 3 + int'($urandom % 12);
    // next request presented while the response is stalled
    req     = make_req(DIV_FN_UNSIGNED, $urandom, 32'd3);
    req_val = 1'b1;
    repeat (hold) begin
      @(negedge clk);
      check_resp("resp", resp, held);
      check_flag("resp_val", resp_val, 1'b1);
      check_flag("req_rdy", req_rdy, 1'b0);
    end
    resp_rdy = 1'b1;
    wait_accept();
  endtask

  function automatic string test_name(input int t);
    case (t)
      0:       return "reset state and back-to-back";
      1:       return "unsigned random";
      2:       return "signed sign combinations";
      3:       return "divide by zero and overflow";
      4:       return "latency";
      default: return "back-pressure";
    endcase
  endfunction

  initial begin
    void'($urandom(32'hebc8));
    reset    = 1'b1;
    req      = '0;
    req_val  = 1'b0;
    resp_rdy = 1'b1;
    repeat (10) @(negedge clk);
    reset = 1'b0;
    for (int t = 0; t < 6; t++) begin
      if (!timed_out) begin
        err_at_start = total_errors();
        case (t)
          0:       test_reset_back_to_back();
          1:       test_unsigned();
          2:       test_signed();
          3:       test_zero_overflow();
          4:       test_latency();
          default: test_back_pressure();
        endcase
        wait_idle();
        if (timed_out || total_errors() != err_at_start) begin
          tests_failed++;
          $display("test %0d %s: failed", t, test_name(t));
        end else begin
          $display("test %0d %s: passed", t, test_name(t));
        end
      end
    end
    $display("summary: %0d tests failed, %0d checks, %0d errors, %0d assertion failures",
             tests_failed, check_cnt, err_cnt, uut.props.fail_cnt);
    if (total_errors() == 0 && tests_failed == 0 && !timed_out) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule : div_unit_tb

//--- dv/div_unit_props.sv
// ----------------------------------------------------------
// concurrent assertions bound to div_unit
// response hold, ready while busy, fixed response latency
// ----------------------------------------------------------

`timescale 1ns/1ps

module div_unit_props
  import div_msg_pkg::*;
(
  input logic      clk,
  input logic      reset,
  input logic      req_val,
  input logic      req_rdy,
  input div_resp_t resp,
  input logic      resp_val,
  input logic      resp_rdy
);

  // port-level busy that clears on the edge after the transfer
  logic       busy_m;
  logic       fire_m;
  // edges since acceptance counted until resp_val shows up
  logic       run_m;
  logic [7:0] lat_cnt;

  // count of failed assertions
  int         fail_cnt = 0;

  always_ff @(posedge clk) begin
    if (reset) begin
      busy_m  <= 1'b0;
      fire_m  <= 1'b0;
      run_m   <= 1'b0;
      lat_cnt <= '0;
    end else begin
      fire_m <= resp_val && resp_rdy;
      if (req_val && req_rdy) begin
        busy_m  <= 1'b1;
        run_m   <= 1'b1;
        lat_cnt <= '0;
      end else begin
        if (fire_m) begin
          busy_m <= 1'b0;
        end
        if (run_m && !resp_val) begin
          lat_cnt <= lat_cnt + 8'd1;
        end else if (resp_val) begin
          run_m <= 1'b0;
        end
      end
    end
  end

  // response and valid held under back-pressure
  a_resp_hold : assert property (@(posedge clk) disable iff (reset)
    resp_val && !resp_rdy |=> resp_val && $stable(resp))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("resp changed or resp_val dropped while resp_rdy was low");
    end

  // no new request taken while a division is outstanding
  a_busy_rdy : assert property (@(posedge clk) disable iff (reset)
    busy_m |-> !req_rdy)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("req_rdy high while a division is in flight");
    end

  // resp_val rises 34 edges after the acceptance edge
  a_latency : assert property (@(posedge clk) disable iff (reset)
    $rose(resp_val) |-> run_m && (lat_cnt == 8'd34))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("resp_val did not rise 34 edges after acceptance");
    end

endmodule : div_unit_props

bind div_unit div_unit_props props (
  .clk      (clk),
  .reset    (reset),
  .req_val  (req_val),
  .req_rdy  (req_rdy),
  .resp     (resp),
  .resp_val (resp_val),
  .resp_rdy (resp_rdy)
);

//--- dv/div_clk_gen.sv
// ----------------------------------------------------------
// testbench clock source, 100 ns period
// ----------------------------------------------------------

`timescale 1ns/1ps

module div_clk_gen (
  output logic clk
);

  // half of the 100 ns period
  localparam int half_period_ns = 50;

  initial begin
    clk = 1'b0;
    forever #(half_period_ns) clk = ~clk;
  end

endmodule : div_clk_gen

//--- hdl/div_unit.sv
// ----------------------------------------------------------
// iterative divide unit, top level
// request stage, iteration core and response stage
// ----------------------------------------------------------

`timescale 1ns/1ps

module div_unit
  import div_msg_pkg::*;
(
  input  logic      clk,
  input  logic      reset,

  // request port
  input  div_req_t  req,
  input  logic      req_val,
  output logic      req_rdy,

  // response port, remainder high and quotient low
  output div_resp_t resp,
  output logic      resp_val,
  input  logic      resp_rdy
);

  // stage to stage signals
  div_operands_t opnds;
  div_mags_t     mags;
  logic          start;
  logic          done;
  logic          resp_fire;

  // accepts one request, holds operands until the response goes out
  div_req_stage req_stage (
    .clk       (clk),
    .reset     (reset),
    .req       (req),
    .req_val   (req_val),
    .req_rdy   (req_rdy),
    .resp_fire (resp_fire),
    .opnds     (opnds),
    .start     (start)
  );

  // 32 restoring steps on the magnitudes
  div_iter_core iter_core (
    .clk   (clk),
    .reset (reset),
    .start (start),
    .opnds (opnds),
    .mags  (mags),
    .done  (done)
  );

  // signs applied here, response held under back-pressure
  div_resp_stage resp_stage (
    .clk       (clk),
    .reset     (reset),
    .done      (done),
    .mags      (mags),
    .opnds     (opnds),
    .resp      (resp),
    .resp_val  (resp_val),
    .resp_rdy  (resp_rdy),
    .resp_fire (resp_fire)
  );

endmodule : div_unit

//--- hdl/div_resp_stage.sv
// ----------------------------------------------------------
// divider response stage
// sign correction, response register, valid hold
// ----------------------------------------------------------

`timescale 1ns/1ps

module div_resp_stage
  import div_cfg_pkg::*, div_msg_pkg::*;
(
  input  logic          clk,
  input  logic          reset,

  // results from the core
  input  logic          done,
  input  div_mags_t     mags,

  // sign flags, stable in the request stage while busy
  input  div_operands_t opnds,

  // response port
  output div_resp_t     resp,
  output logic          resp_val,
  input  logic          resp_rdy,

  // pulse after the transfer, releases the request stage
  output logic          resp_fire
);

  logic [div_width-1:0] quot_fix;
  logic [div_width-1:0] rem_fix;
  logic                 resp_xfer;

  // ----------------------------------------------------------
  // sign correction
  // ----------------------------------------------------------

  // overflow case needs nothing special
  // 0x80000000 / 1 with quot_neg clear gives 0x80000000, remainder 0
  assign quot_fix = opnds.quot_neg ? -mags.quot_mag : mags.quot_mag;
  assign rem_fix  = opnds.rem_neg ? -mags.rem_mag : mags.rem_mag;

  // transfer on an edge where both are high
  assign resp_xfer = resp_val & resp_rdy;

  // ----------------------------------------------------------
  // response register
  // ----------------------------------------------------------

  // loaded once per division, then held through back-pressure
  always_ff @(posedge clk) begin
    if (done) begin
      resp.rem  <= rem_fix;
      resp.quot <= quot_fix;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      resp_val  <= 1'b0;
      resp_fire <= 1'b0;
    end else begin
      // one cycle after the transfer edge
      resp_fire <= resp_xfer;
      if (done) begin
        resp_val <= 1'b1;
      end else if (resp_xfer) begin
        resp_val <= 1'b0;
      end
    end
  end

endmodule : div_resp_stage

//--- hdl/div_iter_core.sv
// ----------------------------------------------------------
// restoring shift-subtract divider core
// partial and divisor registers, step counter, done pulse
// ----------------------------------------------------------

`timescale 1ns/1ps

module div_iter_core
  import div_cfg_pkg::*, div_msg_pkg::*;
(
  input  logic          clk,
  input  logic          reset,

  // load request from the request stage
  input  logic          start,
  input  div_operands_t opnds,

  // unsigned results, valid while done is high
  output div_mags_t     mags,
  output logic          done
);

  // partial register layout
  //   [2w]      guard bit, set when a subtraction goes negative
  //   [2w-1:w]  running remainder
  //   [w-1:0]   dividend bits shifting out, quotient bits shifting in
  logic [2*div_width:0] part_q;

  // divisor aligned to the remainder half
  logic [2*div_width:0] dvsr_q;

  // one step of combinational work
  logic [2*div_width:0] shifted;
  logic [2*div_width:0] diff;
  logic [2*div_width:0] part_next;

  // sequencing
  logic [div_cnt_width-1:0] cnt_q;
  logic                     running_q;
  logic                     last_step;

  // ----------------------------------------------------------
  // datapath
  // ----------------------------------------------------------

  always_comb begin
    // bring in the next dividend bit
    shifted = part_q << 1;
    // trial subtraction against the aligned divisor
    diff = shifted - dvsr_q;
    if (diff[2*div_width]) begin
      // negative, restore the shifted value and record a zero
      part_next = {shifted[2*div_width:1], 1'b0};
    end else begin
      // fits, keep the difference and record a one
      part_next = {diff[2*div_width:1], 1'b1};
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      // dividend in the low half, remainder starts at zero
      part_q <= {{(div_width + 1){1'b0}}, opnds.mag_a};
      dvsr_q <= {1'b0, opnds.mag_b, {div_width{1'b0}}};
    end else if (running_q) begin
      part_q <= part_next;
    end
  end

  // ----------------------------------------------------------
  // step counter
  // ----------------------------------------------------------

  // count of 1 means this edge performs the final step
  assign last_step = running_q && (cnt_q == div_cnt_width'(1));

  always_ff @(posedge clk) begin
    if (reset) begin
      running_q <= 1'b0;
      cnt_q     <= '0;
      done      <= 1'b0;
    end else begin
      // done is a single cycle pulse
      done <= last_step;
      if (start) begin
        // load edge, steps follow on the next div_steps edges
        running_q <= 1'b1;
        cnt_q     <= div_cnt_width'(div_steps);
      end else if (running_q) begin
        cnt_q <= cnt_q - 1'b1;
        if (last_step) begin
          running_q <= 1'b0;
        end
      end
    end
  end

  // ----------------------------------------------------------
  // results
  // ----------------------------------------------------------

  // divide by zero falls out naturally
  // quotient of all ones and remainder equal to the dividend
  always_comb begin
    mags.quot_mag = part_q[div_width-1:0];
    mags.rem_mag  = part_q[2*div_width-1:div_width];
  end

endmodule : div_iter_core

//--- hdl/div_req_stage.sv
// ----------------------------------------------------------
// divider request stage
// acceptance, busy flag, operand magnitude and sign capture
// ----------------------------------------------------------

`timescale 1ns/1ps

module div_req_stage
  import div_cfg_pkg::*, div_msg_pkg::*;
(
  input  logic          clk,
  input  logic          reset,

  // request port
  input  div_req_t      req,
  input  logic          req_val,
  output logic          req_rdy,

  // response transferred, frees the unit
  input  logic          resp_fire,

  // towards core and response stage
  output div_operands_t opnds,
  output logic          start
);

  // one division in flight at a time
  logic busy;
  logic accept;
  logic is_signed;
  logic sign_a;
  logic sign_b;

  // ----------------------------------------------------------
  // handshake
  // ----------------------------------------------------------

  // ready whenever nothing is in flight
  assign req_rdy = ~busy;
  assign accept  = req_val & req_rdy;

  // sign bits only count in signed mode
  assign is_signed = (req.fn == DIV_FN_SIGNED);
  assign sign_a    = is_signed & req.a[div_width-1];
  assign sign_b    = is_signed & req.b[div_width-1];

  // busy from acceptance until the response stage reports a transfer
  always_ff @(posedge clk) begin
    if (reset) begin
      busy  <= 1'b0;
      start <= 1'b0;
    end else begin
      // start pulses in the cycle after acceptance
      start <= accept;
      if (accept) begin
        busy <= 1'b1;
      end else if (resp_fire) begin
        busy <= 1'b0;
      end
    end
  end

  // ----------------------------------------------------------
  // operand capture
  // ----------------------------------------------------------

  // held stable while busy, the response stage reads the flags late
  always_ff @(posedge clk) begin
    if (accept) begin
      // two's complement magnitude, most negative value maps onto itself
      opnds.mag_a <= sign_a ? -req.a : req.a;
      opnds.mag_b <= sign_b ? -req.b : req.b;
      // quotient negative when signs differ
      opnds.quot_neg <= sign_a ^ sign_b;
      // remainder follows the dividend
      opnds.rem_neg <= sign_a;
    end
  end

endmodule : div_req_stage

//--- hdl/div_msg_pkg.sv
// ----------------------------------------------------------
// divider message types
// function code, request, operand, magnitude and response
// ----------------------------------------------------------

package div_msg_pkg;

  import div_cfg_pkg::*;

  // function code carried with each request
  typedef enum logic {
    DIV_FN_UNSIGNED = 1'b0,
    DIV_FN_SIGNED   = 1'b1
  } div_fn_e;

  // request payload, dividend a and divisor b
  typedef struct packed {
    div_fn_e              fn;
    logic [div_width-1:0] a;
    logic [div_width-1:0] b;
  } div_req_t;

  // captured magnitudes plus result sign flags
  typedef struct packed {
    logic [div_width-1:0] mag_a;
    logic [div_width-1:0] mag_b;
    logic                 quot_neg;
    logic                 rem_neg;
  } div_operands_t;

  // unsigned results straight out of the iteration core
  typedef struct packed {
    logic [div_width-1:0] quot_mag;
    logic [div_width-1:0] rem_mag;
  } div_mags_t;

  // response word, remainder high and quotient low
  typedef struct packed {
    logic [div_width-1:0] rem;
    logic [div_width-1:0] quot;
  } div_resp_t;

endpackage : div_msg_pkg

//--- hdl/div_cfg_pkg.sv
// ----------------------------------------------------------
// divider configuration constants
// operand width, step count and step counter width
// ----------------------------------------------------------

package div_cfg_pkg;

  // operand width in bits, one machine word
  localparam int div_width = 32;

  // restoring division retires one quotient bit per step
  localparam int div_steps = div_width;

  // step counter must hold div_steps itself, so 6 bits for 32
  localparam int div_cnt_width = 6;

endpackage : div_cfg_pkg
